//--- Makefile
BIN := obj_dir/Vntm_write_tb

all: run

$(BIN): ntm_write.f $(wildcard src/*.sv dv/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module ntm_write_tb -f ntm_write.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- include/ntm_write_cases.svh
`ifndef NTM_WRITE_CASES_SVH
`define NTM_WRITE_CASES_SVH

////////////////////////////////////////
// Directed jobs
////////////////////////////////////////

// Row count and fixed gap between enables, per job
localparam int N_DIR = 3;
localparam int DIR_ROWS [N_DIR] = '{1, MAX_ROWS, 2};
localparam int DIR_GAP  [N_DIR] = '{1, 0, 2};

// Add vector per job, column 3 in the top word
localparam logic [LANES*DATA_W-1:0] DIR_A [N_DIR] = '{
  64'h0040_0200_0080_0100,
  64'hFF00_0080_0200_0100,
  64'h0100_8000_7FFF_FF80
};

// Rows of all jobs in order
// Columns: weight, old row, expected row (column 3 leftmost)
localparam int N_DIR_ROWS = 11;
localparam logic [DATA_W+2*LANES*DATA_W-1:0] DIR_ROW [N_DIR_ROWS] = '{
  // Single row, small positive values
  {16'h0180, 64'h0001_0010_0200_0100, 64'h0061_0310_02C0_0280},
  // Full job, weights 1/16 to 8/16
  {16'h0010, 64'h1000_0002_0001_0000, 64'h0FF0_000A_0021_0010},
  {16'h0020, 64'h1000_0002_0001_0100, 64'h0FE0_0012_0041_0120},
  {16'h0030, 64'h1000_0002_0001_0200, 64'h0FD0_001A_0061_0230},
  {16'h0040, 64'h1000_0002_0001_0300, 64'h0FC0_0022_0081_0340},
  {16'h0050, 64'h1000_0002_0001_0400, 64'h0FB0_002A_00A1_0450},
  {16'h0060, 64'h1000_0002_0001_0500, 64'h0FA0_0032_00C1_0560},
  {16'h0070, 64'h1000_0002_0001_0600, 64'h0F90_003A_00E1_0670},
  {16'h0080, 64'h1000_0002_0001_0700, 64'h0F80_0042_0101_0780},
  // Negative operands, truncated products, wrapping sums
  {16'hFE00, 64'h0100_1234_FFFE_7F80, 64'hFF00_1234_0000_8080},
  {16'h0003, 64'hFFFF_8000_7FF0_0001, 64'h0002_7E80_816F_FFFF}
};

////////////////////////////////////////
// Random jobs
////////////////////////////////////////

localparam int N_RAND       = 6;
// Gap drawn from 0 up to this many cycles
localparam int RAND_MAX_GAP = 3;

`endif

//--- dv/ntm_write_tb.sv
`timescale 1ns/1ps

module ntm_write_tb import ntm_write_pkg::*; ();

  logic              CLK = 1'b0;
  logic              RST;
  logic              START;
  logic [ROW_W-1:0]  SIZE_N_IN;
  logic              A_IN_ENABLE;
  logic [DATA_W-1:0] A_IN;
  logic              W_IN_ENABLE;
  logic [DATA_W-1:0] W_IN;
  logic              M_IN_K_ENABLE;
  logic [DATA_W-1:0] M_IN;
  logic              READY;
  logic [DATA_W-1:0] M_OUT;
  logic              M_OUT_K_ENABLE;
  logic              M_OUT_J_ENABLE;

  `include "ntm_write_cases.svh"

  // Current job, from the table or random
  logic [DATA_W-1:0] job_a [LANES];
  logic [DATA_W-1:0] job_w [MAX_ROWS];
  logic [DATA_W-1:0] job_m [MAX_ROWS][LANES];
  logic [DATA_W-1:0] job_e [MAX_ROWS][LANES];

  // Expected words in output order
  logic [DATA_W-1:0] exp_word [$];
  int                exp_cyc [$];
  bit                exp_j [$];
  bit                exp_rdy [$];

  int cyc = 0;
  int limit;
  int words = 0;
  int mismatches = 0;
  int faults = 0;

  ntm_write_top DUT (
    .CLK(CLK), .RST(RST), .START(START), .SIZE_N_IN(SIZE_N_IN), .READY(READY),
    .A_IN_ENABLE(A_IN_ENABLE), .A_IN(A_IN), .W_IN_ENABLE(W_IN_ENABLE), .W_IN(W_IN),
    .M_IN_K_ENABLE(M_IN_K_ENABLE), .M_IN(M_IN), .M_OUT(M_OUT),
    .M_OUT_K_ENABLE(M_OUT_K_ENABLE), .M_OUT_J_ENABLE(M_OUT_J_ENABLE)
  );

  always #10 CLK = ~CLK;

  // Rising edges so far
  always @(posedge CLK) cyc <= cyc + 1;

  // Q8.8 cell update: old + trunc(w*a >>> 8), modulo 2^16
  function automatic logic [DATA_W-1:0] apply_update(input logic [DATA_W-1:0] m,
                                                     input logic [DATA_W-1:0] w,
                                                     input logic [DATA_W-1:0] a);
    logic signed [2*DATA_W-1:0] prod;
    prod = $signed(w) * $signed(a);
    prod = prod >>> FRAC_BITS;
    return m + prod[DATA_W-1:0];
  endfunction

  // Per job: pulses stretched by the worst gap, plus drain
  function automatic int cycle_limit();
    int total;
    total = 0;
    for (int j = 0; j < N_DIR; j++) begin
      total += (DIR_ROWS[j] * (LANES + 1) + LANES) * (DIR_GAP[j] + 1) + 10;
    end
    total += N_RAND * ((MAX_ROWS * (LANES + 1) + LANES) * (RAND_MAX_GAP + 1) + 10);
    // Reset and idle enables
    return 2 * total + 40;
  endfunction

  task automatic wait_gap(input int max_gap, input bit rand_gap);
    int n;
    n = rand_gap ? int'($urandom % (max_gap + 1)) : max_gap;
    repeat (n) @(negedge CLK);
  endtask

  // One enable pulse; 0 add, 1 weight, 2 memory
  task automatic send_word(input int sel, input logic [DATA_W-1:0] data);
    A_IN_ENABLE   = (sel == 0);
    W_IN_ENABLE   = (sel == 1);
    M_IN_K_ENABLE = (sel == 2);
    A_IN = data;
    W_IN = data;
    M_IN = data;
    @(negedge CLK);
    A_IN_ENABLE   = 1'b0;
    W_IN_ENABLE   = 1'b0;
    M_IN_K_ENABLE = 1'b0;
  endtask

  task automatic load_table_job(input int job, input int base);
    logic [DATA_W+2*LANES*DATA_W-1:0] entry;
    for (int k = 0; k < LANES; k++) begin
      job_a[k] = DIR_A[job][k*DATA_W +: DATA_W];
    end
    for (int r = 0; r < DIR_ROWS[job]; r++) begin
      entry    = DIR_ROW[base + r];
      job_w[r] = entry[2*LANES*DATA_W +: DATA_W];
      for (int k = 0; k < LANES; k++) begin
        job_m[r][k] = entry[LANES*DATA_W + k*DATA_W +: DATA_W];
        job_e[r][k] = entry[k*DATA_W +: DATA_W];
      end
    end
  endtask

  task automatic make_random_job(input int rows);
    for (int k = 0; k < LANES; k++) begin
      job_a[k] = DATA_W'($urandom);
    end
    for (int r = 0; r < rows; r++) begin
      job_w[r] = DATA_W'($urandom);
      for (int k = 0; k < LANES; k++) begin
        job_m[r][k] = DATA_W'($urandom);
        job_e[r][k] = apply_update(job_m[r][k], job_w[r], job_a[k]);
      end
    end
  endtask

  task automatic run_job(input int rows, input int max_gap, input bit rand_gap);
    START     = 1'b1;
    SIZE_N_IN = ROW_W'(rows);
    @(negedge CLK);
    START = 1'b0;
    for (int k = 0; k < LANES; k++) begin
      wait_gap(max_gap, rand_gap);
      send_word(0, job_a[k]);
    end
    for (int r = 0; r < rows; r++) begin
      wait_gap(max_gap, rand_gap);
      send_word(1, job_w[r]);
      for (int k = 0; k < LANES; k++) begin
        wait_gap(max_gap, rand_gap);
        send_word(2, job_m[r][k]);
      end
      // Last memory word taken on the edge just passed
      for (int k = 0; k < LANES; k++) begin
        exp_word.push_back(job_e[r][k]);
        exp_cyc.push_back(cyc + 3 + k);
        exp_j.push_back(k == LANES - 1);
        exp_rdy.push_back(k == LANES - 1 && r == rows - 1);
      end
    end
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  task automatic monitor_outputs();
    forever begin
      @(negedge CLK);
      if (RST) begin
        if (M_OUT !== '0 || M_OUT_K_ENABLE !== 1'b0 || M_OUT_J_ENABLE !== 1'b0 ||
            READY !== 1'b0) begin
          mismatches++;
          $display("MISMATCH at %0t: outputs not cleared during reset", $time);
        end
      end else if (M_OUT_K_ENABLE) begin
        if (exp_word.size() == 0) begin
          faults++;
          $display("Extra output word %h at %0t, none was expected", M_OUT, $time);
        end else begin
          if (M_OUT !== exp_word[0]) begin
            mismatches++;
            $display("MISMATCH at %0t: word %0d is %h, expected %h",
                     $time, words, M_OUT, exp_word[0]);
          end
          if (cyc != exp_cyc[0]) begin
            mismatches++;
            $display("MISMATCH at %0t: word %0d in cycle %0d, expected cycle %0d",
                     $time, words, cyc, exp_cyc[0]);
          end
          if (M_OUT_J_ENABLE !== exp_j[0] || READY !== exp_rdy[0]) begin
            mismatches++;
            $display("MISMATCH at %0t: word %0d row flag %b job flag %b, expected %b %b",
                     $time, words, M_OUT_J_ENABLE, READY, exp_j[0], exp_rdy[0]);
          end
          words++;
          void'(exp_word.pop_front());
          void'(exp_cyc.pop_front());
          void'(exp_j.pop_front());
          void'(exp_rdy.pop_front());
        end
      end else begin
        if (M_OUT_J_ENABLE !== 1'b0 || READY !== 1'b0) begin
          faults++;
          $display("Row or job flag high without a word at %0t", $time);
        end
        // Word overdue
        if (exp_cyc.size() != 0 && exp_cyc[0] < cyc) begin
          faults++;
          $display("Output word %0d never appeared, due in cycle %0d", words, exp_cyc[0]);
          words++;
          void'(exp_word.pop_front());
          void'(exp_cyc.pop_front());
          void'(exp_j.pop_front());
          void'(exp_rdy.pop_front());
        end
      end
    end
  endtask

  task automatic watch_timeout();
    while (cyc < limit) @(negedge CLK);
    $display("Timeout after %0d cycles with %0d words still expected", cyc, exp_word.size());
    $display("Checked %0d words: %0d mismatches, %0d other errors", words, mismatches, faults);
    $display("*** FAILED ***");
    $finish;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int base;
    int rows;
    void'($urandom(32'hf39cd2a1));
    RST           = 1'b1;
    START         = 1'b0;
    SIZE_N_IN     = '0;
    A_IN_ENABLE   = 1'b0;
    A_IN          = '0;
    W_IN_ENABLE   = 1'b0;
    W_IN          = '0;
    M_IN_K_ENABLE = 1'b0;
    M_IN          = '0;
    limit         = cycle_limit();
    fork
      monitor_outputs();
      watch_timeout();
    join_none
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    // Stray enables in idle, no output allowed
    send_word(0, 16'h1111);
    send_word(1, 16'h2222);
    send_word(2, 16'h3333);
    repeat (6) @(negedge CLK);
    base = 0;
    for (int j = 0; j < N_DIR; j++) begin
      load_table_job(j, base);
      run_job(DIR_ROWS[j], DIR_GAP[j], 1'b0);
      base += DIR_ROWS[j];
    end
    // Random jobs start as soon as scatter is idle
    for (int j = 0; j < N_RAND; j++) begin
      rows = 1 + int'($urandom % MAX_ROWS);
      make_random_job(rows);
      run_job(rows, RAND_MAX_GAP, 1'b1);
    end
    while (exp_word.size() != 0) @(negedge CLK);
    repeat (8) @(negedge CLK);
    $display("Checked %0d words: %0d mismatches, %0d other errors", words, mismatches, faults);
    if (mismatches == 0 && faults == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- ntm_write.f
+incdir+include
src/ntm_write_pkg.sv
src/ntm_write_scatter.sv
src/ntm_write_lane.sv
src/ntm_write_gather.sv
src/ntm_write_top.sv
dv/ntm_write_tb.sv

//--- src/ntm_write_gather.sv
`timescale 1ns/1ps

module ntm_write_gather import ntm_write_pkg::*; (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         res_valid,
  input  logic                         res_last,
  input  logic [LANES-1:0][DATA_W-1:0] res_word,
  output logic [DATA_W-1:0]            M_OUT,
  output logic                         M_OUT_K_ENABLE,
  output logic                         M_OUT_J_ENABLE,
  output logic                         READY
);

  ////////////////////////////////////////
  // Serializer state
  ////////////////////////////////////////

  // Words still waiting after the one on M_OUT
  logic [DATA_W-1:0] buf_q [LANES-1];
  logic [LANE_W-1:0] left_q;
  // Row being drained is the job's last
  logic              last_q;
  logic              draining;
  logic              final_word;

  assign draining   = (left_q != '0);
  assign final_word = (left_q == LANE_W'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      M_OUT          <= '0;
      M_OUT_K_ENABLE <= 1'b0;
      M_OUT_J_ENABLE <= 1'b0;
      READY          <= 1'b0;
      left_q         <= '0;
      last_q         <= 1'b0;
    end else if (res_valid) begin
      // Column 0 goes out straight away
      M_OUT          <= res_word[0];
      M_OUT_K_ENABLE <= 1'b1;
      M_OUT_J_ENABLE <= 1'b0;
      READY          <= 1'b0;
      left_q         <= LANE_W'(LANES - 1);
      last_q         <= res_last;
    end else if (draining) begin
      M_OUT          <= buf_q[0];
      M_OUT_K_ENABLE <= 1'b1;
      // Row and job flags ride on the final word
      M_OUT_J_ENABLE <= final_word;
      READY          <= final_word && last_q;
      left_q         <= left_q - 1'b1;
    end else begin
      M_OUT_K_ENABLE <= 1'b0;
      M_OUT_J_ENABLE <= 1'b0;
      READY          <= 1'b0;
    end
  end

  // Parallel load, then shift toward entry 0
  always_ff @(posedge CLK) begin
    if (res_valid) begin
      for (int i = 0; i < LANES - 1; i++) begin
        buf_q[i] <= res_word[i+1];
      end
    end else if (draining) begin
      for (int i = 0; i < LANES - 2; i++) begin
        buf_q[i] <= buf_q[i+1];
      end
    end
  end

  // Input pacing keeps rows from overlapping here
  a_no_overrun: assert property (@(posedge CLK) disable iff (RST) res_valid |-> !draining)
    else $error("row result arrived while previous row still draining");

endmodule

//--- src/ntm_write_lane.sv
`timescale 1ns/1ps

module ntm_write_lane import ntm_write_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  logic              a_load,
  input  logic [DATA_W-1:0] a_word,
  input  logic [DATA_W-1:0] w_word,
  input  logic              m_load,
  input  logic [DATA_W-1:0] m_word,
  input  logic              row_go,
  input  logic              row_last,
  output logic              res_valid,
  output logic              res_last,
  output logic [DATA_W-1:0] res_word
);

  // Add element for this column, kept for the job
  logic signed [DATA_W-1:0] a_q;
  // Old cell value of the current row
  logic [DATA_W-1:0] m_q;

  // Full-width product and its Q8.8 realignment
  logic signed [2*DATA_W-1:0] prod_full;
  logic signed [2*DATA_W-1:0] prod_shift;

  // Stage one registers
  logic [DATA_W-1:0] prod_q;
  logic [DATA_W-1:0] old_q;
  logic              v1_q;
  logic              last1_q;

  always_ff @(posedge CLK) begin
    if (a_load) a_q <= a_word;
    if (m_load) m_q <= m_word;
  end

  assign prod_full  = $signed(w_word) * a_q;
  // Arithmetic shift keeps the sign
  assign prod_shift = prod_full >>> FRAC_BITS;

  ////////////////////////////////////////
  // Two-stage pipeline
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Truncate to one word
    prod_q   <= prod_shift[DATA_W-1:0];
    old_q    <= m_q;
    // Sum wraps modulo 2^16
    res_word <= prod_q + old_q;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      v1_q      <= 1'b0;
      last1_q   <= 1'b0;
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else begin
      v1_q      <= row_go;
      last1_q   <= row_last;
      res_valid <= v1_q;
      res_last  <= last1_q;
    end
  end

  // Old value must be complete before launch
  a_load_vs_go: assert property (@(posedge CLK) disable iff (RST) !(m_load && row_go))
    else $error("memory word loaded during row launch");

endmodule

//--- src/ntm_write_pkg.sv
package ntm_write_pkg;

  ////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////

  // Signed Q8.8 data word
  localparam int DATA_W    = 16;
  // Fraction bits dropped after multiply
  localparam int FRAC_BITS = 8;

  ////////////////////////////////////////
  // Array shape
  ////////////////////////////////////////

  // One lane per column
  localparam int LANES    = 4;
  localparam int LANE_W   = 2;
  // Row count limit and SIZE_N_IN width
  localparam int MAX_ROWS = 8;
  localparam int ROW_W    = 4;

  ////////////////////////////////////////
  // Job controller states
  ////////////////////////////////////////

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOAD_A = 2'd1;
  localparam logic [1:0] ST_ROW_W  = 2'd2;
  localparam logic [1:0] ST_ROW_M  = 2'd3;

endpackage

//--- src/ntm_write_scatter.sv
`timescale 1ns/1ps

module ntm_write_scatter import ntm_write_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  // Job control
  input  logic              START,
  input  logic [ROW_W-1:0]  SIZE_N_IN,
  // Host streams
  input  logic              A_IN_ENABLE,
  input  logic [DATA_W-1:0] A_IN,
  input  logic              W_IN_ENABLE,
  input  logic [DATA_W-1:0] W_IN,
  input  logic              M_IN_K_ENABLE,
  input  logic [DATA_W-1:0] M_IN,
  // Lane side
  output logic [LANES-1:0]  a_load,
  output logic [DATA_W-1:0] a_word,
  output logic [DATA_W-1:0] w_word,
  output logic [LANES-1:0]  m_load,
  output logic [DATA_W-1:0] m_word,
  output logic              row_go,
  output logic              row_last
);

  ////////////////////////////////////////
  // Controller registers
  ////////////////////////////////////////

  logic [1:0]        state_q;
  logic [ROW_W-1:0]  rows_left_q;
  logic [LANE_W-1:0] col_q;

  // Enables accepted in their own phase only
  logic a_fire;
  logic w_fire;
  logic m_fire;
  logic col_end;
  logic [LANES-1:0] col_onehot;

  assign a_fire  = (state_q == ST_LOAD_A) && A_IN_ENABLE;
  assign w_fire  = (state_q == ST_ROW_W) && W_IN_ENABLE;
  assign m_fire  = (state_q == ST_ROW_M) && M_IN_K_ENABLE;
  assign col_end = (col_q == LANE_W'(LANES - 1));

  // Column counter picks the lane
  assign col_onehot = LANES'(1) << col_q;

  assign a_load = a_fire ? col_onehot : '0;
  assign m_load = m_fire ? col_onehot : '0;
  // Data words go to every lane, strobe selects
  assign a_word = A_IN;
  assign m_word = M_IN;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= ST_IDLE;
      rows_left_q <= '0;
      col_q       <= '0;
      row_go      <= 1'b0;
      row_last    <= 1'b0;
    end else begin
      // One-cycle launch pulse
      row_go <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (START) begin
            rows_left_q <= SIZE_N_IN;
            col_q       <= '0;
            state_q     <= ST_LOAD_A;
          end
        end
        ST_LOAD_A: begin
          if (a_fire) begin
            col_q <= col_q + 1'b1;
            if (col_end) state_q <= ST_ROW_W;
          end
        end
        ST_ROW_W: begin
          if (w_fire) state_q <= ST_ROW_M;
        end
        default: begin
          if (m_fire) begin
            col_q <= col_q + 1'b1;
            // Last column of the row, launch the lanes
            if (col_end) begin
              row_go      <= 1'b1;
              row_last    <= (rows_left_q == ROW_W'(1));
              rows_left_q <= rows_left_q - 1'b1;
              state_q     <= (rows_left_q == ROW_W'(1)) ? ST_IDLE : ST_ROW_W;
            end
          end
        end
      endcase
    end
  end

  // Row weight, held until the next row's weight
  always_ff @(posedge CLK) begin
    if (w_fire) w_word <= W_IN;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Stray enables are dropped, warn only
  a_out_of_phase: assert property (@(posedge CLK) disable iff (RST)
    (A_IN_ENABLE |-> state_q == ST_LOAD_A) and
    (W_IN_ENABLE |-> state_q == ST_ROW_W) and
    (M_IN_K_ENABLE |-> state_q == ST_ROW_M))
    else $warning("enable out of phase, ignored");

  // Row count must fit the job limits
  a_size_range: assert property (@(posedge CLK) disable iff (RST)
    (START && state_q == ST_IDLE) |->
      (SIZE_N_IN != '0 && SIZE_N_IN <= ROW_W'(MAX_ROWS)))
    else $error("SIZE_N_IN out of range at START");

endmodule

//--- src/ntm_write_top.sv
`timescale 1ns/1ps

module ntm_write_top import ntm_write_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  // Job control
  input  logic              START,
  input  logic [ROW_W-1:0]  SIZE_N_IN,
  output logic              READY,
  // Add vector
  input  logic              A_IN_ENABLE,
  input  logic [DATA_W-1:0] A_IN,
  // Row weight
  input  logic              W_IN_ENABLE,
  input  logic [DATA_W-1:0] W_IN,
  // Old memory row
  input  logic              M_IN_K_ENABLE,
  input  logic [DATA_W-1:0] M_IN,
  // Updated memory row
  output logic [DATA_W-1:0] M_OUT,
  output logic              M_OUT_K_ENABLE,
  output logic              M_OUT_J_ENABLE
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  // Scatter to lanes
  logic [LANES-1:0]  a_load;
  logic [DATA_W-1:0] a_word;
  logic [DATA_W-1:0] w_word;
  logic [LANES-1:0]  m_load;
  logic [DATA_W-1:0] m_word;
  logic              row_go;
  logic              row_last;

  // Lanes to gather
  logic [LANES-1:0]              lane_valid;
  logic [LANES-1:0]              lane_last;
  logic [LANES-1:0][DATA_W-1:0]  lane_word;

  ntm_write_scatter u_scatter (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .SIZE_N_IN    (SIZE_N_IN),
    .A_IN_ENABLE  (A_IN_ENABLE),
    .A_IN         (A_IN),
    .W_IN_ENABLE  (W_IN_ENABLE),
    .W_IN         (W_IN),
    .M_IN_K_ENABLE(M_IN_K_ENABLE),
    .M_IN         (M_IN),
    .a_load       (a_load),
    .a_word       (a_word),
    .w_word       (w_word),
    .m_load       (m_load),
    .m_word       (m_word),
    .row_go       (row_go),
    .row_last     (row_last)
  );

  // One update lane per column
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    ntm_write_lane u_lane (
      .CLK      (CLK),
      .RST      (RST),
      .a_load   (a_load[i]),
      .a_word   (a_word),
      .w_word   (w_word),
      .m_load   (m_load[i]),
      .m_word   (m_word),
      .row_go   (row_go),
      .row_last (row_last),
      .res_valid(lane_valid[i]),
      .res_last (lane_last[i]),
      .res_word (lane_word[i])
    );
  end

  // Lane 0 speaks for the whole row
  ntm_write_gather u_gather (
    .CLK           (CLK),
    .RST           (RST),
    .res_valid     (lane_valid[0]),
    .res_last      (lane_last[0]),
    .res_word      (lane_word),
    .M_OUT         (M_OUT),
    .M_OUT_K_ENABLE(M_OUT_K_ENABLE),
    .M_OUT_J_ENABLE(M_OUT_J_ENABLE),
    .READY         (READY)
  );

endmodule
